// File: src/exec_pkg.sv
`default_nettype none

package exec_pkg;

    localparam int XLEN  = 32;
    localparam int TAG_W = 8;
    localparam int ROB_W = 6;

    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    // ALU func3
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;

    localparam logic [2:0] F3_MUL   = 3'b000;
    localparam logic [2:0] F3_MULH  = 3'b001;
    localparam logic [2:0] F3_MULHU = 3'b011;

    localparam int ADD_RS_DEPTH = 8;
    localparam int MUL_RS_DEPTH = 4;
    localparam int DIV_RS_DEPTH = 4;
    localparam int MUL_STAGES   = 3;

    typedef struct packed {
        logic [6:0]       opcode;
        logic [6:0]       funct7;
        logic [2:0]       func3;
        logic [XLEN-1:0]  op1_value;
        logic [XLEN-1:0]  op2_value;
        logic [TAG_W-1:0] op1_tag;
        logic [TAG_W-1:0] op2_tag;
        logic [TAG_W-1:0] rd_tag;
        logic [1:0]       op_ready;  // Bit 0 is operand 1
        logic [XLEN-1:0]  immediate;
        logic [ROB_W-1:0] rob_id;
    } dispatch_t;

    typedef struct packed {
        logic [XLEN-1:0]  op1_value;
        logic [XLEN-1:0]  op2_value;
        logic [TAG_W-1:0] op1_tag;
        logic [TAG_W-1:0] op2_tag;
        logic [1:0]       op_ready;
        logic [TAG_W-1:0] rd_tag;
        logic [ROB_W-1:0] rob_id;
        logic [2:0]       func3;
        logic             use_imm;   // Operand 2 holds the immediate
        logic             alt;       // SUB or SRA
    } uop_t;

    typedef struct packed {
        logic             valid;
        logic [2:0]       func3;
        logic             alt;
        logic [XLEN-1:0]  a;
        logic [XLEN-1:0]  b;
        logic [TAG_W-1:0] rd_tag;
        logic [ROB_W-1:0] rob_id;
    } issue_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        logic [ROB_W-1:0] rob_id;
        logic [XLEN-1:0]  value;
    } result_t;

endpackage

`default_nettype wire

// File: src/rs_dispatch_router.sv
`timescale 1ns/10ps
`default_nettype none

module rs_dispatch_router (
    input  logic               dispatch_valid,
    input  exec_pkg::dispatch_t dispatch,
    input  logic               add_full,
    input  logic               mul_full,
    input  logic               div_full,
    output logic               add_write,
    output logic               mul_write,
    output logic               div_write,
    output exec_pkg::uop_t     uop,
    output logic               dispatch_stall
);

    logic is_muldiv;
    logic to_add;
    logic to_mul;
    logic to_div;

    always_comb begin
        is_muldiv = (dispatch.opcode == exec_pkg::OPC_OP) &&
                    (dispatch.funct7 == exec_pkg::FUNCT7_MULDIV);
        to_add = dispatch_valid && (dispatch.opcode != 7'd0) && !is_muldiv;  // Zero is a bubble
        to_mul = dispatch_valid && is_muldiv && !dispatch.func3[2];
        to_div = dispatch_valid && is_muldiv && dispatch.func3[2];

        dispatch_stall = (to_add && add_full) || (to_mul && mul_full) || (to_div && div_full);
        add_write = to_add && !add_full;
        mul_write = to_mul && !mul_full;
        div_write = to_div && !div_full;
    end

    always_comb begin
        uop.op1_value = dispatch.op1_value;
        uop.op1_tag   = dispatch.op1_tag;
        uop.rd_tag    = dispatch.rd_tag;
        uop.rob_id    = dispatch.rob_id;
        uop.func3     = dispatch.func3;
        uop.use_imm   = dispatch.opcode != exec_pkg::OPC_OP;
        // Immediate ops only use funct7 bit 5 for SRAI
        uop.alt       = dispatch.funct7[5] &&
                        (!uop.use_imm || dispatch.func3 == exec_pkg::F3_SRL);
        if (uop.use_imm) begin
            uop.op2_value = dispatch.immediate;
            uop.op2_tag   = '0;
            uop.op_ready  = {1'b1, dispatch.op_ready[0]};
        end else begin
            uop.op2_value = dispatch.op2_value;
            uop.op2_tag   = dispatch.op2_tag;
            uop.op_ready  = dispatch.op_ready;
        end
    end

endmodule

`default_nettype wire

// File: src/reservation_station.sv
`timescale 1ns/10ps
`default_nettype none

module reservation_station #(
    parameter int DEPTH = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              write,
    input  exec_pkg::uop_t    uop,
    input  exec_pkg::result_t add_result,
    input  exec_pkg::result_t mul_result,
    input  exec_pkg::result_t div_result,
    input  logic              issue_ready,
    output logic              full,
    output exec_pkg::issue_t  issue
);

    exec_pkg::uop_t          entry [DEPTH];
    exec_pkg::uop_t          woken [DEPTH];
    exec_pkg::uop_t          new_uop;
    exec_pkg::uop_t          pick;
    exec_pkg::result_t [2:0] buses;
    logic [DEPTH-1:0]        busy;
    logic [DEPTH-1:0]        free;
    logic [DEPTH-1:0]        rdy;
    logic [DEPTH-1:0]        wr_sel;
    logic [DEPTH-1:0]        iss_sel;

    // Snoop all result buses, only operands still waiting take a value
    function automatic exec_pkg::uop_t wake(exec_pkg::uop_t u, exec_pkg::result_t [2:0] bus);
        exec_pkg::uop_t w;
        w = u;
        for (int b = 0; b < 3; b++) begin
            if (bus[b].valid && !w.op_ready[0] && bus[b].tag == w.op1_tag) begin
                w.op1_value   = bus[b].value;
                w.op_ready[0] = 1'b1;
            end
            if (bus[b].valid && !w.use_imm && !w.op_ready[1] && bus[b].tag == w.op2_tag) begin
                w.op2_value   = bus[b].value;
                w.op_ready[1] = 1'b1;
            end
        end
        return w;
    endfunction

    assign buses = {div_result, mul_result, add_result};
    assign full  = &busy;

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            woken[i] = wake(entry[i], buses);
            rdy[i]   = busy[i] && (&woken[i].op_ready);  // Bus bypass for same-cycle wakeup
        end
        new_uop = wake(uop, buses);
        free    = ~busy;
        wr_sel  = free & (~free + DEPTH'(1));            // Lowest free slot
        iss_sel = issue_ready ? (rdy & (~rdy + DEPTH'(1))) : '0;
    end

    always_comb begin
        pick = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (iss_sel[i]) begin
                pick = woken[i];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy  <= '0;
            issue <= '0;
        end else begin
            busy         <= (busy & ~iss_sel) | (write ? wr_sel : '0);
            issue.valid  <= |iss_sel;
            issue.func3  <= pick.func3;
            issue.alt    <= pick.alt;
            issue.a      <= pick.op1_value;
            issue.b      <= pick.op2_value;
            issue.rd_tag <= pick.rd_tag;
            issue.rob_id <= pick.rob_id;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (write && wr_sel[i]) begin
                entry[i] <= new_uop;
            end else begin
                entry[i] <= woken[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: src/add_unit.sv
`timescale 1ns/10ps
`default_nettype none

module add_unit (
    input  logic              clk,
    input  logic              reset,
    input  exec_pkg::issue_t  issue,
    output exec_pkg::result_t result
);

    logic [exec_pkg::XLEN-1:0] alu;
    logic [4:0]                shamt;

    always_comb begin
        shamt = issue.b[4:0];
        case (issue.func3)
            exec_pkg::F3_ADD:  alu = issue.alt ? issue.a - issue.b : issue.a + issue.b;
            exec_pkg::F3_SLL:  alu = issue.a << shamt;
            exec_pkg::F3_SLT:  alu = exec_pkg::XLEN'($signed(issue.a) < $signed(issue.b));
            exec_pkg::F3_SLTU: alu = exec_pkg::XLEN'(issue.a < issue.b);
            exec_pkg::F3_XOR:  alu = issue.a ^ issue.b;
            exec_pkg::F3_SRL: begin
                if (issue.alt) begin
                    alu = $signed(issue.a) >>> shamt;  // SRA keeps the sign
                end else begin
                    alu = issue.a >> shamt;
                end
            end
            exec_pkg::F3_OR:   alu = issue.a | issue.b;
            default:           alu = issue.a & issue.b;  // AND
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result <= '0;
        end else begin
            result.valid  <= issue.valid;
            result.tag    <= issue.rd_tag;
            result.rob_id <= issue.rob_id;
            result.value  <= alu;
        end
    end

endmodule

`default_nettype wire

// File: src/mul_unit.sv
`timescale 1ns/10ps
`default_nettype none

module mul_unit (
    input  logic              clk,
    input  logic              reset,
    input  exec_pkg::issue_t  issue,
    output exec_pkg::result_t result
);

    logic                               a_sx;
    logic                               b_sx;
    logic signed [exec_pkg::XLEN:0]     a_q;
    logic signed [exec_pkg::XLEN:0]     b_q;
    logic signed [2*exec_pkg::XLEN+1:0] prod_q;
    logic [exec_pkg::MUL_STAGES-2:0]    vld_q;
    logic [exec_pkg::MUL_STAGES-2:0]    hi_q;
    logic [exec_pkg::TAG_W-1:0]         tag_q [exec_pkg::MUL_STAGES-1];
    logic [exec_pkg::ROB_W-1:0]         rob_q [exec_pkg::MUL_STAGES-1];

    always_comb begin
        a_sx = issue.func3 != exec_pkg::F3_MULHU;  // MULHSU keeps a signed
        b_sx = issue.func3 == exec_pkg::F3_MULH;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vld_q  <= '0;
            result <= '0;
        end else begin
            vld_q         <= {vld_q[exec_pkg::MUL_STAGES-3:0], issue.valid};
            result.valid  <= vld_q[exec_pkg::MUL_STAGES-2];
            result.tag    <= tag_q[exec_pkg::MUL_STAGES-2];
            result.rob_id <= rob_q[exec_pkg::MUL_STAGES-2];
            result.value  <= hi_q[exec_pkg::MUL_STAGES-2] ?
                             prod_q[2*exec_pkg::XLEN-1:exec_pkg::XLEN] :
                             prod_q[exec_pkg::XLEN-1:0];
        end
    end

    always_ff @(posedge clk) begin
        a_q      <= {a_sx & issue.a[exec_pkg::XLEN-1], issue.a};  // Stage 1
        b_q      <= {b_sx & issue.b[exec_pkg::XLEN-1], issue.b};
        prod_q   <= a_q * b_q;                                    // Stage 2
        hi_q     <= {hi_q[exec_pkg::MUL_STAGES-3:0], issue.func3 != exec_pkg::F3_MUL};
        tag_q[0] <= issue.rd_tag;
        rob_q[0] <= issue.rob_id;
        for (int s = 1; s < exec_pkg::MUL_STAGES - 1; s++) begin
            tag_q[s] <= tag_q[s-1];
            rob_q[s] <= rob_q[s-1];
        end
    end

endmodule

`default_nettype wire

// File: src/div_unit.sv
`timescale 1ns/10ps
`default_nettype none

module div_unit (
    input  logic              clk,
    input  logic              reset,
    input  exec_pkg::issue_t  issue,
    output logic              div_ready,
    output exec_pkg::result_t result
);

    logic                        busy;
    logic [4:0]                  count;
    logic [exec_pkg::XLEN-1:0]   quo;       // Shifts the dividend out, quotient in
    logic [exec_pkg::XLEN-1:0]   rem;
    logic [exec_pkg::XLEN-1:0]   dvs;
    logic [exec_pkg::XLEN-1:0]   dividend;
    logic                        neg_q;
    logic                        neg_r;
    logic                        want_rem;
    logic                        div_zero;
    logic                        a_neg;
    logic                        b_neg;
    logic [exec_pkg::XLEN:0]     shifted;
    logic [exec_pkg::XLEN+1:0]   diff;
    logic [exec_pkg::XLEN-1:0]   step_quo;
    logic [exec_pkg::XLEN-1:0]   step_rem;
    logic [exec_pkg::XLEN-1:0]   q_fix;
    logic [exec_pkg::XLEN-1:0]   r_fix;
    logic [exec_pkg::XLEN-1:0]   final_value;

    // Hold off the station while an issued op is still on its way in
    assign div_ready = !busy && !issue.valid;

    always_comb begin
        a_neg    = !issue.func3[0] && issue.a[exec_pkg::XLEN-1];  // DIV and REM are signed
        b_neg    = !issue.func3[0] && issue.b[exec_pkg::XLEN-1];
        shifted  = {rem, quo[exec_pkg::XLEN-1]};
        diff     = {1'b0, shifted} - {2'b00, dvs};
        step_rem = diff[exec_pkg::XLEN+1] ? shifted[exec_pkg::XLEN-1:0] : diff[exec_pkg::XLEN-1:0];
        step_quo = {quo[exec_pkg::XLEN-2:0], !diff[exec_pkg::XLEN+1]};
        // MIN / -1 falls out of the magnitudes as MIN with zero remainder
        q_fix    = neg_q ? -step_quo : step_quo;
        r_fix    = neg_r ? -step_rem : step_rem;
        if (want_rem) begin
            final_value = div_zero ? dividend : r_fix;
        end else begin
            final_value = div_zero ? '1 : q_fix;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy   <= 1'b0;
            count  <= '0;
            result <= '0;
        end else begin
            result.valid <= 1'b0;
            if (!busy && issue.valid) begin
                busy          <= 1'b1;
                count         <= '0;
                result.tag    <= issue.rd_tag;
                result.rob_id <= issue.rob_id;
            end else if (busy) begin
                count <= count + 5'd1;
                if (count == 5'd31) begin  // Last restoring step
                    busy         <= 1'b0;
                    result.valid <= 1'b1;
                    result.value <= final_value;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && issue.valid) begin
            quo      <= a_neg ? -issue.a : issue.a;
            dvs      <= b_neg ? -issue.b : issue.b;
            rem      <= '0;
            dividend <= issue.a;
            neg_q    <= a_neg ^ b_neg;
            neg_r    <= a_neg;
            want_rem <= issue.func3[1];
            div_zero <= issue.b == '0;
        end else if (busy) begin
            quo <= step_quo;
            rem <= step_rem;
        end
    end

endmodule

`default_nettype wire

// File: src/exec_cluster_top.sv
`timescale 1ns/10ps
`default_nettype none

module exec_cluster_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                dispatch_valid,
    input  exec_pkg::dispatch_t dispatch,
    output logic                dispatch_stall,
    output exec_pkg::result_t   add_result,
    output exec_pkg::result_t   mul_result,
    output exec_pkg::result_t   div_result
);

    exec_pkg::uop_t   uop;
    exec_pkg::issue_t add_issue;
    exec_pkg::issue_t mul_issue;
    exec_pkg::issue_t div_issue;
    logic             add_write;
    logic             mul_write;
    logic             div_write;
    logic             add_full;
    logic             mul_full;
    logic             div_full;
    logic             div_ready;

    rs_dispatch_router router0 (
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .add_full       (add_full),
        .mul_full       (mul_full),
        .div_full       (div_full),
        .add_write      (add_write),
        .mul_write      (mul_write),
        .div_write      (div_write),
        .uop            (uop),
        .dispatch_stall (dispatch_stall)
    );

    reservation_station #(.DEPTH(exec_pkg::ADD_RS_DEPTH)) add_rs (
        .clk (clk), .reset (reset), .write (add_write), .uop (uop),
        .add_result (add_result), .mul_result (mul_result), .div_result (div_result),
        .issue_ready (1'b1), .full (add_full), .issue (add_issue)
    );

    reservation_station #(.DEPTH(exec_pkg::MUL_RS_DEPTH)) mul_rs (
        .clk (clk), .reset (reset), .write (mul_write), .uop (uop),
        .add_result (add_result), .mul_result (mul_result), .div_result (div_result),
        .issue_ready (1'b1), .full (mul_full), .issue (mul_issue)
    );

    reservation_station #(.DEPTH(exec_pkg::DIV_RS_DEPTH)) div_rs (
        .clk (clk), .reset (reset), .write (div_write), .uop (uop),
        .add_result (add_result), .mul_result (mul_result), .div_result (div_result),
        .issue_ready (div_ready), .full (div_full), .issue (div_issue)
    );

    add_unit add0 (.clk (clk), .reset (reset), .issue (add_issue), .result (add_result));

    mul_unit mul0 (.clk (clk), .reset (reset), .issue (mul_issue), .result (mul_result));

    div_unit div0 (
        .clk       (clk),
        .reset     (reset),
        .issue     (div_issue),
        .div_ready (div_ready),
        .result    (div_result)
    );

endmodule

`default_nettype wire

// File: dv/exec_cluster_tb.sv
`timescale 1ns/10ps
`default_nettype none

module exec_cluster_tb;

    localparam int CLK_NS  = 8;
    localparam int T_RESET = 40;
    localparam int T_ADD   = 120;
    localparam int T_MUL   = 60;
    localparam int T_DIV   = 10 * 40;
    localparam int T_WAKE  = 120;
    localparam int T_STALL = 8 * 40;
    localparam int T_ALL   = T_RESET + T_ADD + T_MUL + T_DIV + T_WAKE + T_STALL;
    localparam logic [6:0] OPC_IMM = 7'b0010011;

    logic                clk;
    logic                reset;
    logic                dispatch_valid;
    logic                dispatch_stall;
    exec_pkg::dispatch_t dispatch;
    exec_pkg::result_t   add_result;
    exec_pkg::result_t   mul_result;
    exec_pkg::result_t   div_result;

    logic [31:0] rng;
    int          errors;
    int          start_errors;
    int          tests_run;
    int          failed_tests;
    int          beats;
    int          sends_done;
    int          first_stall;
    logic [31:0] exp_val [64];
    logic [31:0] got_val [64];
    logic [7:0]  got_tag [64];
    int          exp_bus [64];
    bit          pending [64];
    bit          got [64];
    time         got_time [64];
    time         disp_time [64];

    exec_cluster_top dut0 (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_stall (dispatch_stall),
        .add_result     (add_result),
        .mul_result     (mul_result),
        .div_result     (div_result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #((2 * T_ALL + 200) * CLK_NS);
        $display("Watchdog expired before the tests finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                            logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] mul_ref(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        logic [63:0] sa;
        logic [63:0] sb;
        logic [63:0] p;
        sa = (f3 != 3'd3 && a[31]) ? {32'hffff_ffff, a} : {32'h0, a};
        sb = (f3 == 3'd1 && b[31]) ? {32'hffff_ffff, b} : {32'h0, b};
        p  = sa * sb;
        return (f3 == 3'd0) ? p[31:0] : p[63:32];
    endfunction

    function automatic logic [31:0] div_ref(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        if (b == 32'd0) return f3[1] ? a : 32'hffff_ffff;
        if (!f3[0] && a == 32'h8000_0000 && b == 32'hffff_ffff) return f3[1] ? 32'd0 : a;
        case (f3)
            3'd4:    return 32'($signed(a) / $signed(b));
            3'd5:    return a / b;
            3'd6:    return 32'($signed(a) % $signed(b));
            default: return a % b;
        endcase
    endfunction

    function automatic exec_pkg::dispatch_t make_op(logic [6:0] opc, logic [6:0] f7,
            logic [2:0] f3, logic [31:0] a, logic [31:0] b, logic [1:0] rdy,
            logic [7:0] t1, logic [5:0] rob);
        exec_pkg::dispatch_t d;
        d           = '0;
        d.opcode    = opc;
        d.funct7    = f7;
        d.func3     = f3;
        d.op1_value = a;
        d.op2_value = b;
        d.immediate = b;
        d.op1_tag   = t1;
        d.op_ready  = rdy;
        d.rd_tag    = {2'b10, rob};  // Destination tag derived from rob id
        d.rob_id    = rob;
        return d;
    endfunction

    task automatic expect_op(input int rob, input int bus, input logic [31:0] val);
        pending[rob] = 1'b1;
        got[rob]     = 1'b0;
        exp_bus[rob] = bus;
        exp_val[rob] = val;
    endtask

    // Holds the inputs until the router takes them
    task automatic send(input exec_pkg::dispatch_t d);
        logic stalled;
        dispatch_valid <= 1'b1;
        dispatch       <= d;
        do begin
            @(negedge clk);
            stalled = dispatch_stall;
            if (stalled && first_stall < 0) first_stall = sends_done;
            @(posedge clk);
        end while (stalled);
        disp_time[d.rob_id] = $time;
        sends_done++;
    endtask

    task automatic idle(input int n);
        dispatch_valid <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic record(input int bus, input exec_pkg::result_t r);
        if (r.valid) begin
            beats++;
            if (!pending[r.rob_id]) begin
                errors++;
                $display("Unexpected result on bus %0d for rob %0d", bus, r.rob_id);
            end else if (got[r.rob_id]) begin
                errors++;
                $display("Duplicate result on bus %0d for rob %0d", bus, r.rob_id);
            end else if (bus != exp_bus[r.rob_id]) begin
                errors++;
                $display("Result for rob %0d came on bus %0d instead of bus %0d",
                         r.rob_id, bus, exp_bus[r.rob_id]);
            end else begin
                got[r.rob_id]      = 1'b1;
                got_val[r.rob_id]  = r.value;
                got_tag[r.rob_id]  = r.tag;
                got_time[r.rob_id] = $time - CLK_NS / 2;  // Edge that launched it
            end
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            record(0, add_result);
            record(1, mul_result);
            record(2, div_result);
        end
    end

    task automatic wait_results(input string name, input int budget);
        int n;
        bit done;
        n    = 0;
        done = 1'b0;
        while (!done && n < budget) begin
            @(posedge clk);
            n++;
            done = 1'b1;
            for (int i = 0; i < 64; i++) begin
                if (pending[i] && !got[i]) begin
                    done = 1'b0;
                end
            end
        end
        for (int i = 0; i < 64; i++) begin
            if (pending[i] && !got[i]) begin
                errors++;
                $display("%s: result for rob %0d never arrived", name, i);
            end else if (pending[i]) begin
                if (got_val[i] !== exp_val[i]) begin
                    errors++;
                    $display("[FAIL] %s rob %0d value expected %h actual %h",
                             name, i, exp_val[i], got_val[i]);
                end
                if (got_tag[i] !== {2'b10, 6'(i)}) begin
                    errors++;
                    $display("[FAIL] %s rob %0d tag expected %h actual %h",
                             name, i, {2'b10, 6'(i)}, got_tag[i]);
                end
            end
            pending[i] = 1'b0;  // Later beats for this rob count as extras
        end
    endtask

    task automatic check_latency(input string name, input int rob, input int cycles);
        if (got[rob] && (got_time[rob] - disp_time[rob]) != cycles * CLK_NS) begin
            errors++;
            $display("[FAIL] %s latency expected %0d actual %0d", name, cycles,
                     (got_time[rob] - disp_time[rob]) / CLK_NS);
        end
    endtask

    task automatic end_test(input string name);
        repeat (4) @(posedge clk);
        tests_run++;
        if (errors != start_errors) failed_tests++;
        $display("Test %s finished with %0d errors", name, errors - start_errors);
        start_errors = errors;
    endtask

    task automatic test_reset();
        @(negedge clk);
        if (add_result.valid || mul_result.valid || div_result.valid) begin
            errors++;
            $display("A result valid is high after reset");
        end
        if (dispatch_stall) begin
            errors++;
            $display("Dispatch stall is high after reset");
        end
        @(posedge clk);
        beats = 0;
        send(make_op(7'd0, 7'd0, 3'd0, 32'd1, 32'd2, 2'b11, 8'd0, 6'd1));
        idle(T_RESET / 2);
        if (beats != 0) begin
            errors++;
            $display("A bubble produced %0d result beats", beats);
        end
        end_test("reset");
    endtask

    task automatic test_add();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic        imm;
        logic        alt;
        for (int i = 0; i < 12; i++) begin
            a   = next_rand();
            b   = next_rand();
            r   = next_rand();
            imm = r[3];
            alt = r[4] && (!imm || r[2:0] == 3'd5);  // Immediate forms only keep SRAI
            expect_op(i, 0, alu_ref(r[2:0], alt, a, b));
            send(make_op(imm ? OPC_IMM : exec_pkg::OPC_OP, r[4] ? 7'h20 : 7'h00, r[2:0],
                         a, b, 2'b11, 8'd0, 6'(i)));
        end
        a = next_rand() | 32'h8000_0000;  // Negative so SRA must fill with ones
        expect_op(12, 0, alu_ref(3'd5, 1'b1, a, 32'd9));
        send(make_op(exec_pkg::OPC_OP, 7'h20, 3'd5, a, 32'd9, 2'b11, 8'd0, 6'd12));
        idle(0);
        wait_results("add", T_ADD / 2);
        a = next_rand();
        expect_op(20, 0, a + 32'd77);
        send(make_op(OPC_IMM, 7'd0, 3'd0, a, 32'd77, 2'b11, 8'd0, 6'd20));
        idle(0);
        wait_results("add", T_ADD / 2);
        check_latency("add", 20, 2);
        end_test("add");
    endtask

    task automatic test_mul();
        logic [31:0] a;
        logic [31:0] b;
        for (int i = 0; i < 5; i++) begin
            a = next_rand();
            b = next_rand();
            expect_op(i, 1, mul_ref(3'(i % 4), a, b));
            send(make_op(exec_pkg::OPC_OP, 7'd1, 3'(i % 4), a, b, 2'b11, 8'd0, 6'(i)));
            if (i == 3) begin
                idle(0);
                wait_results("mul", T_MUL / 2);  // Drain before the isolated one
            end
        end
        idle(0);
        wait_results("mul", T_MUL / 2);
        check_latency("mul", 4, 4);
        end_test("mul");
    endtask

    task automatic test_div();
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  f3;
        for (int i = 0; i < 10; i++) begin
            a  = next_rand();
            b  = (i < 4) ? next_rand() : 32'd0;
            f3 = 3'(4 + i % 4);
            if (i >= 8) begin
                a  = 32'h8000_0000;
                b  = 32'hffff_ffff;
                f3 = (i == 8) ? 3'd4 : 3'd6;
            end
            expect_op(i, 2, div_ref(f3, a, b));
            send(make_op(exec_pkg::OPC_OP, 7'd1, f3, a, b, 2'b11, 8'd0, 6'(i)));
        end
        idle(0);
        wait_results("div", T_DIV);
        end_test("div");
    endtask

    task automatic test_wakeup();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] pv;
        logic [31:0] mv;
        a  = next_rand();
        b  = next_rand() | 32'd1;
        c  = next_rand();
        pv = div_ref(3'd4, a, b);
        expect_op(0, 2, pv);
        send(make_op(exec_pkg::OPC_OP, 7'd1, 3'd4, a, b, 2'b11, 8'd0, 6'd0));
        expect_op(1, 0, alu_ref(3'd0, 1'b0, pv, c));
        send(make_op(exec_pkg::OPC_OP, 7'd0, 3'd0, 32'hdead_beef, c, 2'b10, 8'h80, 6'd1));
        a  = next_rand();
        b  = next_rand();
        mv = mul_ref(3'd0, a, b);
        expect_op(2, 1, mv);
        send(make_op(exec_pkg::OPC_OP, 7'd1, 3'd0, a, b, 2'b11, 8'd0, 6'd2));
        idle(4);  // Consumer is taken on the edge ending the broadcast cycle
        expect_op(3, 0, alu_ref(3'd0, 1'b1, mv, c));
        send(make_op(exec_pkg::OPC_OP, 7'h20, 3'd0, 32'hdead_beef, c, 2'b10, 8'h82, 6'd3));
        idle(0);
        wait_results("wakeup", T_WAKE);
        if (got[2] && got_time[2] + CLK_NS != disp_time[3]) begin
            errors++;
            $display("Second consumer was not dispatched during the multiply broadcast");
        end
        end_test("wakeup");
    endtask

    task automatic test_stall();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        first_stall = -1;
        sends_done  = 0;
        for (int i = 0; i < 8; i++) begin
            a = next_rand();
            b = next_rand();
            r = next_rand();
            expect_op(i, 2, div_ref({1'b1, r[1:0]}, a, b));
            send(make_op(exec_pkg::OPC_OP, 7'd1, {1'b1, r[1:0]}, a, b, 2'b11, 8'd0, 6'(i)));
        end
        idle(0);
        if (first_stall < 0 || first_stall > 5) begin
            errors++;
            $display("Dispatch stall did not rise before the sixth divide was taken");
        end
        wait_results("stall", T_STALL);
        end_test("stall");
    endtask

    initial begin
        rng            = 32'h7638_5f56;
        errors         = 0;
        start_errors   = 0;
        tests_run      = 0;
        failed_tests   = 0;
        beats          = 0;
        sends_done     = 0;
        first_stall    = -1;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        for (int i = 0; i < 64; i++) begin
            pending[i] = 1'b0;
            got[i]     = 1'b0;
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);
        test_reset();
        test_add();
        test_mul();
        test_div();
        test_wakeup();
        test_stall();
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, failed_tests, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: exec_cluster.f
src/exec_pkg.sv
src/rs_dispatch_router.sv
src/reservation_station.sv
src/add_unit.sv
src/mul_unit.sv
src/div_unit.sv
src/exec_cluster_top.sv
dv/exec_cluster_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f exec_cluster.f \
    --top-module exec_cluster_tb \
    -o exec_cluster_sim

./obj_dir/exec_cluster_sim > sim.log
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
